// ==== common/popeye_pkg.sv ====
// Shared bus structs, select enums and width constants for the main CPU board
package popeye_pkg;

    localparam int ADDR_W = 16;            // CPU address width
    localparam int DATA_W = 8;             // CPU data width

    // Every data path is one byte wide
    typedef logic [DATA_W-1:0] byte_t;

    // One CPU bus cycle, scrambled address as seen on the pins
    typedef struct packed {
        logic [ADDR_W-1:0] addr;           // Scrambled address
        byte_t             wdata;          // Write data from the CPU
        logic              mreq;           // Memory request
        logic              iorq;           // I/O request
        logic              rd;
        logic              wr;
    } cpu_bus_t;

    // ROM download port
    typedef struct packed {
        logic [14:0] addr;
        byte_t       data;
        logic        we;
    } prog_t;

    // Player controls, active as delivered by the cabinet
    typedef struct packed {
        logic [6:0] joystick1;
        logic [6:0] joystick2;
        logic [1:0] start;
        logic       coin;
        logic       service;
    } cabinet_t;

    // Selects that leave for the video boards
    typedef struct packed {
        logic obj_sel;                     // Sprite/video select
        logic bg_sel;                      // Background write, stretched
    } vid_strobe_t;

    // Source of the read data on cpu_din
    typedef enum logic [2:0] {
        DEV_NONE = 3'd0,
        DEV_ROM  = 3'd1,
        DEV_RAM  = 3'd2,
        DEV_CAB  = 3'd3,
        DEV_SEC  = 3'd4,
        DEV_PSG  = 3'd5
    } dev_sel_t;

    // Sound chip bus phase, encoded as {bdir, bc1}
    typedef enum logic [1:0] {
        PSG_IDLE  = 2'b00,
        PSG_READ  = 2'b01,
        PSG_WRITE = 2'b10,
        PSG_LATCH = 2'b11
    } psg_phase_t;

endpackage

// ==== source/main_bus.sv ====
// Main bus glue: address descrambling, device decode, bg latch and read mux
`timescale 1ns/1ns

module main_bus import popeye_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  cpu_bus_t          cpu,
    input  byte_t             rom_q,
    input  byte_t             ram_q,
    input  byte_t             sec_q,
    input  byte_t             cab_q,
    input  byte_t             psg_q,
    output logic [ADDR_W-1:0] addr,
    output byte_t             wdata,
    output logic              rom_cs,
    output logic              ram_we,
    output logic              sec_cs,
    output logic              sec_wr,
    output logic              cab_rd,
    output psg_phase_t        psg_phase,
    output vid_strobe_t       vid,
    output byte_t             cpu_din
);

    logic     ram_cs;
    logic     obj_now, bg_now, bg_l;
    logic     io_rd, io_wr, psg_rd;
    logic     bdir, bc1;
    dev_sel_t dev_now, dev_q;

    ////////////////////////////////////////////////////////////
    // Address descrambling
    assign addr[2:0]   = ~cpu.addr[2:0];
    assign addr[3]     = ~cpu.addr[4];
    assign addr[4]     = ~cpu.addr[5];
    assign addr[5]     = ~cpu.addr[9];
    assign addr[6]     = cpu.addr[3];        // Plain swaps, no inversion
    assign addr[7]     = cpu.addr[6];
    assign addr[8]     = cpu.addr[7];
    assign addr[9]     = cpu.addr[8];
    assign addr[15:10] = cpu.addr[15:10];    // Upper bits untouched

    assign wdata = cpu.wdata;

    ////////////////////////////////////////////////////////////
    // Memory space, top three logical bits
    always_comb begin
        rom_cs  = 1'b0;
        ram_cs  = 1'b0;
        obj_now = 1'b0;
        bg_now  = 1'b0;
        sec_cs  = 1'b0;
        if (!cpu.iorq) begin               // I/O cycles never hit memory
            case (addr[15:13])
                3'b100:  ram_cs  = cpu.mreq && !addr[11]; // 2 kB, no alias
                3'b101:  obj_now = cpu.mreq;
                3'b110:  bg_now  = cpu.mreq;
                3'b111:  sec_cs  = 1'b1;
                default: rom_cs  = 1'b1;                  // 0xxx to 7xxx
            endcase
        end
    end

    assign ram_we = ram_cs && cpu.wr;
    assign sec_wr = sec_cs && cpu.wr;

    // I/O space, only A1..A0 decoded
    assign io_rd  = cpu.iorq && cpu.rd;
    assign io_wr  = cpu.iorq && cpu.wr;
    assign psg_rd = io_rd && (addr[1:0] == 2'd0);
    assign cab_rd = io_rd && (addr[1:0] != 2'd0);

    // Sound chip control lines
    assign bdir      = io_wr;
    assign bc1       = (io_wr && addr[0]) || psg_rd;
    assign psg_phase = psg_phase_t'({bdir, bc1});

    ////////////////////////////////////////////////////////////
    // Video strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bg_l <= 1'b0;
        end else if (cen) begin
            bg_l <= bg_now;                // One enable cycle of stretch
        end
    end

    assign vid.obj_sel = obj_now;
    assign vid.bg_sel  = bg_now | bg_l;

    ////////////////////////////////////////////////////////////
    // Read source, registered with the device data
    always_comb begin
        dev_now = DEV_NONE;
        if (psg_rd) begin
            dev_now = DEV_PSG;
        end else if (cab_rd) begin
            dev_now = DEV_CAB;
        end else if (cpu.rd) begin
            if (rom_cs) dev_now = DEV_ROM;
            else if (ram_cs) dev_now = DEV_RAM;
            else if (sec_cs) dev_now = DEV_SEC;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dev_q <= DEV_NONE;
        end else if (cen) begin
            dev_q <= dev_now;              // Tracks whichever q was loaded
        end
    end

    always_comb begin
        case (dev_q)
            DEV_ROM: cpu_din = rom_q;
            DEV_RAM: cpu_din = ram_q;
            DEV_CAB: cpu_din = cab_q;
            DEV_SEC: cpu_din = sec_q;
            DEV_PSG: cpu_din = psg_q;
            default: cpu_din = '0;         // Open bus reads as zero
        endcase
    end

endmodule

// ==== source/main_rom.sv ====
// Program ROM, filled from the download port, read under the CPU clock enable
`timescale 1ns/1ns

module main_rom import popeye_pkg::*; #(
    parameter int ROM_AW = 15
) (
    input  logic              clk,
    input  logic              cen,
    input  logic [ROM_AW-1:0] addr,
    input  prog_t             prog,
    output byte_t             q
);

    byte_t mem [0:(1 << ROM_AW)-1];        // No preload, download only

    // Download side runs at full clock rate
    always_ff @(posedge clk) begin
        if (prog.we) begin
            mem[prog.addr[ROM_AW-1:0]] <= prog.data;
        end
    end

    // CPU side
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[addr];                // Registered, one enable of latency
        end
    end

endmodule

// ==== source/work_ram.sv ====
// Work RAM for the main CPU, single port with registered read
`timescale 1ns/1ns

module work_ram import popeye_pkg::*; #(
    parameter int RAM_AW = 11
) (
    input  logic              clk,
    input  logic              cen,
    input  logic [RAM_AW-1:0] addr,
    input  byte_t             wdata,
    input  logic              we,
    output byte_t             q
);

    byte_t mem [0:(1 << RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= wdata;        // Write lands on the first enable
            end
            q <= mem[addr];                // Old data on a write cycle
        end
    end

endmodule

// ==== security/security_prot.sv ====
// Protection chip: two stored bytes read back through a programmable shifter
`timescale 1ns/1ns

module security_prot import popeye_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cen,
    input  logic  a0,
    input  byte_t wdata,
    input  logic  cs,
    input  logic  wr,
    output byte_t q
);

    logic [2:0]  shift;                    // Left shift amount
    byte_t       cur_b, prev_b;
    logic [15:0] pair_sh;

    // Upper byte of the shifted pair is what the game sees
    assign pair_sh = {cur_b, prev_b} << shift;

    ////////////////////////////////////////////////////////////
    // Register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift  <= '0;
            cur_b  <= '0;
            prev_b <= '0;
        end else if (cen && cs && wr) begin
            if (a0) begin
                shift <= wdata[2:0];       // Only three bits kept
            end else begin
                prev_b <= cur_b;           // Byte pair moves along
                cur_b  <= wdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (cen && cs && !wr) begin
            q <= a0 ? {5'd0, shift} : pair_sh[15:8];
        end
    end

endmodule

// ==== source/cabinet_io.sv ====
// Cabinet input ports: coin/start, and both joysticks with their bits reordered
`timescale 1ns/1ns

module cabinet_io import popeye_pkg::*; (
    input  logic       clk,
    input  logic       cen,
    input  logic [1:0] port,
    input  logic       rd,
    input  cabinet_t   cab,
    output byte_t      q
);

    byte_t port_val;

    // Unused bits float high on the board
    always_comb begin
        port_val = 8'hff;
        case (port)
            2'd1: begin
                port_val[7]   = cab.coin;
                port_val[6]   = cab.service;
                port_val[3:2] = cab.start;
            end
            2'd2: begin                            // Player 2
                port_val[1:0] = cab.joystick2[1:0]; // Right, left
                port_val[2]   = cab.joystick2[3];   // Up
                port_val[3]   = cab.joystick2[2];   // Down
                port_val[4]   = cab.joystick2[4];   // Punch
            end
            2'd3: begin                            // Player 1
                port_val[1:0] = cab.joystick1[1:0];
                port_val[2]   = cab.joystick1[3];
                port_val[3]   = cab.joystick1[2];
                port_val[4]   = cab.joystick1[4];
            end
            default: port_val = 8'hff;             // Port 0 belongs to the PSG
        endcase
    end

    always_ff @(posedge clk) begin
        if (cen && rd) begin
            q <= port_val;
        end
    end

endmodule

// ==== psg/psg_regs.sv ====
// Sound chip bus interface and register file, port A flip/DIP mux, port B DIPs
`timescale 1ns/1ns

module psg_regs import popeye_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  psg_phase_t phase,
    input  byte_t      wdata,
    input  logic [3:0] dip_sw1,
    input  logic [7:0] dip_sw2,
    output byte_t      q,
    output logic       rv_n
);

    localparam logic [3:0] REG_IOA = 4'd14;
    localparam logic [3:0] REG_IOB = 4'd15;

    logic [3:0] reg_addr;                  // Latched register number
    byte_t      regs [0:15];
    byte_t      port_a, port_b;
    logic [2:0] dip_mux;

    ////////////////////////////////////////////////////////////
    // Port wiring
    assign port_a  = regs[REG_IOA];
    assign dip_mux = port_a[3:1];          // Picks one DIP 2 switch
    assign rv_n    = port_a[0];            // Screen flip, active low

    always_comb begin
        port_b[3:0] = dip_sw1;
        port_b[6:4] = 3'b000;
        port_b[7]   = dip_sw2[dip_mux];
    end

    ////////////////////////////////////////////////////////////
    // Address latch and register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_addr <= '0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= (i == int'(REG_IOA)) ? 8'hff : 8'h00; // Port A idles high
            end
        end else if (cen) begin
            case (phase)
                PSG_LATCH: reg_addr       <= wdata[3:0];
                PSG_WRITE: regs[reg_addr] <= wdata;
                default:   reg_addr       <= reg_addr;
            endcase
        end
    end

    // Read register, port B comes from the input pins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (cen && phase == PSG_READ) begin
            q <= (reg_addr == REG_IOB) ? port_b : regs[reg_addr];
        end
    end

endmodule

// ==== source/popeye_main.sv ====
// Main CPU board top: bus glue, memories, protection, inputs and sound chip ports
`timescale 1ns/1ns

module popeye_main import popeye_pkg::*; #(
    parameter int ROM_AW = 15,
    parameter int RAM_AW = 11
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  cpu_bus_t    cpu,
    input  prog_t       prog,
    input  cabinet_t    cab,
    input  logic [3:0]  dip_sw1,
    input  logic [7:0]  dip_sw2,
    output byte_t       cpu_din,
    output vid_strobe_t vid,
    output logic        rv_n
);

    logic [ADDR_W-1:0] addr;               // Descrambled address
    byte_t             wdata;
    logic              rom_cs;
    logic              ram_we;
    logic              sec_cs, sec_wr;
    logic              cab_rd;
    psg_phase_t        psg_phase;
    byte_t             rom_q, ram_q, sec_q, cab_q, psg_q;

    ////////////////////////////////////////////////////////////
    // Decode and read mux
    main_bus i_main_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .cpu       (cpu),
        .rom_q     (rom_q),
        .ram_q     (ram_q),
        .sec_q     (sec_q),
        .cab_q     (cab_q),
        .psg_q     (psg_q),
        .addr      (addr),
        .wdata     (wdata),
        .rom_cs    (rom_cs),
        .ram_we    (ram_we),
        .sec_cs    (sec_cs),
        .sec_wr    (sec_wr),
        .cab_rd    (cab_rd),
        .psg_phase (psg_phase),
        .vid       (vid),
        .cpu_din   (cpu_din)
    );

    ////////////////////////////////////////////////////////////
    // Memories
    main_rom #(.ROM_AW(ROM_AW)) i_main_rom (
        .clk  (clk),
        .cen  (cen && rom_cs),             // Hold q outside ROM cycles
        .addr (addr[ROM_AW-1:0]),
        .prog (prog),
        .q    (rom_q)
    );

    work_ram #(.RAM_AW(RAM_AW)) i_work_ram (
        .clk   (clk),
        .cen   (cen),
        .addr  (addr[RAM_AW-1:0]),
        .wdata (wdata),
        .we    (ram_we),
        .q     (ram_q)
    );

    ////////////////////////////////////////////////////////////
    // Peripherals
    security_prot i_security_prot (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .a0    (addr[0]),
        .wdata (wdata),
        .cs    (sec_cs),
        .wr    (sec_wr),
        .q     (sec_q)
    );

    cabinet_io i_cabinet_io (
        .clk  (clk),
        .cen  (cen),
        .port (addr[1:0]),
        .rd   (cab_rd),
        .cab  (cab),
        .q    (cab_q)
    );

    psg_regs i_psg_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .phase   (psg_phase),
        .wdata   (wdata),
        .dip_sw1 (dip_sw1),
        .dip_sw2 (dip_sw2),
        .q       (psg_q),
        .rv_n    (rv_n)
    );

endmodule

// ==== tb/popeye_main_chk.sv ====
// Bound checker for the main board top: flip in reset, strobe exclusion, PSG phase on reads
`timescale 1ns/1ns

module popeye_main_chk import popeye_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input cpu_bus_t    cpu,
    input vid_strobe_t vid,
    input psg_phase_t  psg_phase,
    input logic        rv_n
);

    logic reset_held;                      // Reset seen on the previous edge

    initial reset_held = 1'b0;

    always @(posedge clk) begin
        reset_held <= !rst_n;
    end

    ////////////////////////////////////////////////////////////
    // Port A comes out of reset as all ones
    a_flip_in_reset: assert property (@(posedge clk) (!rst_n && reset_held) |-> rv_n)
        else $error("rv_n low while reset is held");

    // Sprite and background selects are separate ranges
    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(vid.obj_sel && vid.bg_sel))
        else $error("obj_sel and bg_sel high together");

    a_no_latch_on_rd: assert property (@(posedge clk) disable iff (!rst_n)
        cpu.rd |-> (psg_phase != PSG_LATCH))
        else $error("PSG address latch during a CPU read");

endmodule

bind popeye_main popeye_main_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu       (cpu),
    .vid       (vid),
    .psg_phase (psg_phase),
    .rv_n      (rv_n)
);

// ==== tb/popeye_main_tb.sv ====
// Testbench for the main CPU board: ROM download, table-driven bus cycles, model compare
`timescale 1ns/1ns

module popeye_main_tb import popeye_pkg::*; ();

    typedef enum logic [2:0] {
        OP_MEM_WR,
        OP_MEM_RD,
        OP_ROM_RD,
        OP_IO_WR,
        OP_IO_RD,
        OP_FLIP,
        OP_OBJ,
        OP_BG
    } op_t;

    // One stimulus row, logical address before scrambling
    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        byte_t       data;
        cabinet_t    cab;
        logic [3:0]  dip1;
        logic [7:0]  dip2;
        byte_t       exp;                  // Data byte, strobe pair or flip bit
    } row_t;

    localparam int ROM_LOAD = 64;          // Bytes pushed through the download port
    localparam int MARGIN   = 100;

    logic        clk, rst_n, cen;
    cpu_bus_t    cpu;
    prog_t       prog;
    cabinet_t    cab;
    logic [3:0]  dip_sw1;
    logic [7:0]  dip_sw2;
    byte_t       cpu_din;
    vid_strobe_t vid;
    logic        rv_n;

    byte_t       rom_model [0:ROM_LOAD-1];
    row_t        table_q [$];
    logic [31:0] lcg_state;
    int          errors, checks, cycles, cycle_limit;

    popeye_main i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .cpu     (cpu),
        .prog    (prog),
        .cab     (cab),
        .dip_sw1 (dip_sw1),
        .dip_sw2 (dip_sw2),
        .cpu_din (cpu_din),
        .vid     (vid),
        .rv_n    (rv_n)
    );

    ////////////////////////////////////////////////////////////
    // Clock, CPU enable every other edge, watchdog
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cen = 1'b0;
        forever begin
            @(negedge clk);
            cen = ~cen;
        end
    end

    initial begin
        cycles = 0;
        while (cycle_limit == 0 || cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the table did not finish", cycles);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference helpers
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Spread the loaded bytes over most address bits
    function automatic logic [14:0] rom_load_addr(input int idx);
        logic [31:0] a;
        a = 32'(idx) * 32'h0000_0111;
        return a[14:0];
    endfunction

    // Logical to pin order, inverse of the board wiring
    function automatic logic [15:0] scramble(input logic [15:0] l);
        logic [15:0] s;
        s[2:0]   = ~l[2:0];
        s[4]     = ~l[3];
        s[5]     = ~l[4];
        s[9]     = ~l[5];
        s[3]     = l[6];
        s[6]     = l[7];
        s[7]     = l[8];
        s[8]     = l[9];
        s[15:10] = l[15:10];
        return s;
    endfunction

    function automatic byte_t cab_model(input logic [1:0] port, input cabinet_t c);
        byte_t      v;
        logic [6:0] j;
        v = 8'hff;                         // Idle bits read high
        j = (port == 2'd3) ? c.joystick1 : c.joystick2;
        if (port == 2'd1) begin
            v[7]   = c.coin;
            v[6]   = c.service;
            v[3:2] = c.start;
        end else if (port != 2'd0) begin
            v[1:0] = j[1:0];
            v[2]   = j[3];                 // Up and down swap places
            v[3]   = j[2];
            v[4]   = j[4];
        end
        return v;
    endfunction

    function automatic cabinet_t make_cab(input logic [6:0] j1, input logic [6:0] j2,
                                          input logic [1:0] st, input logic coin,
                                          input logic svc);
        cabinet_t c;
        c.joystick1 = j1;
        c.joystick2 = j2;
        c.start     = st;
        c.coin      = coin;
        c.service   = svc;
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_data(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_strobe(input vid_strobe_t got, input vid_strobe_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED vid got 0x%01h expected 0x%01h", got, exp);
        end
    endtask

    task automatic check_flip(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED rv_n got 0x%01h expected 0x%01h", got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus drive
    task automatic drive_bus(input logic [15:0] laddr, input byte_t d,
                             input logic io, input logic wr);
        cpu.addr  = scramble(laddr);
        cpu.wdata = d;
        cpu.mreq  = !io;
        cpu.iorq  = io;
        cpu.rd    = !wr;
        cpu.wr    = wr;
    endtask

    task automatic bus_idle();
        cpu = '0;                          // Lands in ROM space, no strobes
    endtask

    task automatic wait_enabled(input int n);
        repeat (n) begin
            @(posedge clk);
            while (cen !== 1'b1) @(posedge clk);
        end
    endtask

    task automatic add_row(input op_t op, input logic [15:0] addr, input byte_t data,
                           input cabinet_t c, input logic [3:0] d1, input logic [7:0] d2,
                           input byte_t exp);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.cab  = c;
        r.dip1 = d1;
        r.dip2 = d2;
        r.exp  = exp;
        table_q.push_back(r);
    endtask

    task automatic make_rom_model();
        lcg_state = 32'h315a_5790;
        for (int i = 0; i < ROM_LOAD; i++) begin
            lcg_state    = lcg_next(lcg_state);
            rom_model[i] = lcg_state[23:16];
        end
    endtask

    task automatic load_rom();
        for (int i = 0; i < ROM_LOAD; i++) begin
            @(negedge clk);
            prog.addr = rom_load_addr(i);
            prog.data = rom_model[i];
            prog.we   = 1'b1;              // One byte per clock, cen ignored
        end
        @(negedge clk);
        prog = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    task automatic build_table();
        int       rom_pick [6];
        cabinet_t c0, ca, cb, cc;
        rom_pick = '{0, 7, 19, 33, 46, 63};
        c0 = make_cab(7'h7f, 7'h7f, 2'b11, 1'b1, 1'b1);
        ca = make_cab(7'h2a, 7'h55, 2'b01, 1'b0, 1'b1);
        cb = make_cab(7'h19, 7'h66, 2'b10, 1'b1, 1'b0);
        cc = make_cab(7'h04, 7'h08, 2'b00, 1'b1, 1'b1);
        add_row(OP_FLIP, 16'h0000, 8'h00, c0, 4'hf, 8'hff, 8'h01);   // Port A reset
        foreach (rom_pick[k]) begin
            add_row(OP_ROM_RD, {1'b0, rom_load_addr(rom_pick[k])}, 8'h00, c0, 4'hf, 8'hff,
                    rom_model[rom_pick[k]]);
        end
        // Work RAM, 0x8810 must not land on 0x8010
        add_row(OP_MEM_WR, 16'h8010, 8'h5a, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_WR, 16'h83a5, 8'hc3, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_WR, 16'h87fe, 8'h3c, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_WR, 16'h8810, 8'ha5, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_RD, 16'h8010, 8'h00, c0, 4'hf, 8'hff, 8'h5a);
        add_row(OP_MEM_RD, 16'h83a5, 8'h00, c0, 4'hf, 8'hff, 8'hc3);
        add_row(OP_MEM_RD, 16'h87fe, 8'h00, c0, 4'hf, 8'hff, 8'h3c);
        add_row(OP_MEM_RD, 16'h8810, 8'h00, c0, 4'hf, 8'hff, 8'h00);
        // Protection, shift 3 on the pair 0x3412
        add_row(OP_MEM_WR, 16'he001, 8'h0b, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_WR, 16'he000, 8'h12, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_WR, 16'he000, 8'h34, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_MEM_RD, 16'he000, 8'h00, c0, 4'hf, 8'hff, 8'ha0);
        add_row(OP_MEM_RD, 16'he001, 8'h00, c0, 4'hf, 8'hff, 8'h03);
        // Cabinet ports
        add_row(OP_IO_RD, 16'h0001, 8'h00, ca, 4'hf, 8'hff, cab_model(2'd1, ca));
        add_row(OP_IO_RD, 16'h0002, 8'h00, cb, 4'hf, 8'hff, cab_model(2'd2, cb));
        add_row(OP_IO_RD, 16'h0003, 8'h00, cb, 4'hf, 8'hff, cab_model(2'd3, cb));
        add_row(OP_IO_RD, 16'h0001, 8'h00, cc, 4'hf, 8'hff, cab_model(2'd1, cc));
        // Sound chip registers and ports
        add_row(OP_IO_WR, 16'h0001, 8'h03, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_IO_WR, 16'h0000, 8'h77, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_IO_RD, 16'h0000, 8'h00, c0, 4'hf, 8'hff, 8'h77);
        add_row(OP_IO_WR, 16'h0001, 8'h0e, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_IO_WR, 16'h0000, 8'h0a, c0, 4'hf, 8'hff, 8'h00);  // Flip, mux 5
        add_row(OP_FLIP, 16'h0000, 8'h00, c0, 4'hf, 8'hff, 8'h00);
        add_row(OP_IO_WR, 16'h0001, 8'h0f, c0, 4'h9, 8'h20, 8'h00);
        add_row(OP_IO_RD, 16'h0000, 8'h00, c0, 4'h9, 8'h20, 8'h89);
        add_row(OP_IO_WR, 16'h0001, 8'h0e, c0, 4'h6, 8'hdb, 8'h00);
        add_row(OP_IO_WR, 16'h0000, 8'h05, c0, 4'h6, 8'hdb, 8'h00);  // No flip, mux 2
        add_row(OP_FLIP, 16'h0000, 8'h00, c0, 4'h6, 8'hdb, 8'h01);
        add_row(OP_IO_WR, 16'h0001, 8'h0f, c0, 4'h6, 8'hdb, 8'h00);
        add_row(OP_IO_RD, 16'h0000, 8'h00, c0, 4'h6, 8'hdb, 8'h06);
        // Video strobes, {obj_sel, bg_sel} while the access is held
        add_row(OP_OBJ, 16'ha123, 8'h00, c0, 4'hf, 8'hff, 8'h02);
        add_row(OP_BG,  16'hc456, 8'h11, c0, 4'hf, 8'hff, 8'h01);
    endtask

    task automatic run_row(input int idx, input row_t r);
        int  err_before;
        op_t op;
        err_before = errors;
        op         = r.op;
        @(negedge clk);
        cab     = r.cab;
        dip_sw1 = r.dip1;
        dip_sw2 = r.dip2;
        case (op)
            OP_MEM_WR, OP_IO_WR: begin
                drive_bus(r.addr, r.data, op == OP_IO_WR, 1'b1);
                wait_enabled(1);           // Write lands on the first enable
                @(negedge clk);
                bus_idle();
            end
            OP_MEM_RD, OP_ROM_RD, OP_IO_RD: begin
                drive_bus(r.addr, r.data, op == OP_IO_RD, 1'b0);
                wait_enabled(2);
                @(negedge clk);            // Before the third enabled edge
                check_data("cpu_din", cpu_din, r.exp);
                bus_idle();
            end
            OP_FLIP: check_flip(rv_n, r.exp[0]);
            OP_OBJ: begin
                drive_bus(r.addr, r.data, 1'b0, 1'b0);
                #1;
                check_strobe(vid, vid_strobe_t'(r.exp[1:0]));
                wait_enabled(1);
                @(negedge clk);
                bus_idle();
                #1;
                check_strobe(vid, vid_strobe_t'(2'b00));
            end
            default: begin
                drive_bus(r.addr, r.data, 1'b0, 1'b1);
                #1;
                check_strobe(vid, vid_strobe_t'(r.exp[1:0]));
                wait_enabled(1);
                @(negedge clk);
                bus_idle();
                #1;
                check_strobe(vid, vid_strobe_t'(2'b01));    // Stretch still high
                wait_enabled(1);
                @(negedge clk);
                #1;
                check_strobe(vid, vid_strobe_t'(2'b00));
            end
        endcase
        $display("row %0d %s: %s", idx, op.name(), (errors == err_before) ? "ok" : "FAIL");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst_n   = 1'b0;
        cpu     = '0;
        prog    = '0;
        cab     = make_cab(7'h7f, 7'h7f, 2'b11, 1'b1, 1'b1);
        dip_sw1 = 4'hf;
        dip_sw2 = 8'hff;
        errors  = 0;
        checks  = 0;
        make_rom_model();
        build_table();
        cycle_limit = ROM_LOAD + 16 * table_q.size() + MARGIN;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_data("cpu_din", cpu_din, 8'h00);                  // Reset state
        check_strobe(vid, vid_strobe_t'(2'b00));
        load_rom();
        foreach (table_q[i]) begin
            run_row(i, table_q[i]);
        end
        repeat (2) @(negedge clk);
        $display("rows %0d, checks %0d, errors %0d", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/popeye_pkg.sv
source/main_bus.sv
source/main_rom.sv
source/work_ram.sv
security/security_prot.sv
source/cabinet_io.sv
psg/psg_regs.sv
source/popeye_main.sv
tb/popeye_main_chk.sv
tb/popeye_main_tb.sv

// ==== Makefile ====
# Verilator build and run for the main CPU board testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := popeye_main_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
